// ==== fc_event_params.svh ====
// Event unit parameters for widths, queue depth, queue interrupt line and register map
`ifndef FC_EVENT_PARAMS_SVH
`define FC_EVENT_PARAMS_SVH

// ****************************************
// Event side
// ****************************************
`define FC_EVT_ID_WIDTH     8
`define FC_EVT_LINES        32
`define FC_EVT_FIFO_DEPTH   4
`define FC_IRQ_ID_WIDTH     5

// Interrupt line fed by the peripheral event queue
`define FC_IRQ_QUEUE_LINE   26

// ****************************************
// APB register port
// ****************************************
`define FC_APB_ADDR_WIDTH   12
`define FC_APB_DATA_WIDTH   32

// Register offsets
`define FC_REG_MASK_OFS     'h0
`define FC_REG_PENDING_OFS  'h4
`define FC_REG_EVTID_OFS    'h8

`endif

// ==== fc_event_pkg.sv ====
// Event side types shared by intake, queue and interrupt controller
`default_nettype none

`include "fc_event_params.svh"

package fc_event_pkg;

    // ****************************************
    // Peripheral events
    // ****************************************

    // ID carried by a peripheral event through the queue
    typedef logic [`FC_EVT_ID_WIDTH-1:0] evt_id_t;

    // ****************************************
    // Event and interrupt lines
    // ****************************************

    // One bit per event line and per interrupt line
    typedef logic [`FC_EVT_LINES-1:0] evt_lines_t;

    // Interrupt number as seen by the core
    typedef logic [`FC_IRQ_ID_WIDTH-1:0] irq_id_t;

endpackage

`default_nettype wire

// ==== fc_reg_pkg.sv ====
// Register side types for the APB port of the interrupt controller
`default_nettype none

`include "fc_event_params.svh"

package fc_reg_pkg;

    // APB address and data words
    typedef logic [`FC_APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [`FC_APB_DATA_WIDTH-1:0] apb_data_t;

    // Register picked by an APB address
    typedef enum logic [1:0] {
        REG_MASK,
        REG_PENDING,
        REG_EVTID,
        REG_NONE
    } reg_sel_e;

endpackage

`default_nettype wire

// ==== fc_apb_if.sv ====
// APB register port bundle between the bus master and the register block
`default_nettype none

interface fc_apb_if;

    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    fc_reg_pkg::apb_addr_t paddr;
    fc_reg_pkg::apb_data_t pwdata;
    fc_reg_pkg::apb_data_t prdata;

    // Master side of the port
    modport bus (
        output psel,
        output penable,
        output pwrite,
        output paddr,
        output pwdata,
        input  prdata
    );

    // Register block side with no wait states and no error response
    modport regs (
        input  psel,
        input  penable,
        input  pwrite,
        input  paddr,
        input  pwdata,
        output prdata
    );

endinterface

`default_nettype wire

// ==== fc_event_intake.sv ====
// Event intake that edge-detects event lines and feeds peripheral events to the queue
`default_nettype none

module fc_event_intake (
    input  wire logic                    clk_i,
    input  wire logic                    rst_n_i,

    input  wire fc_event_pkg::evt_lines_t events_i,

    input  wire logic                    event_fifo_valid_i,
    input  wire fc_event_pkg::evt_id_t   event_fifo_data_i,
    output logic                         event_fifo_fulln_o,

    input  wire logic                    fifo_full_i,
    output logic                         push_o,
    output fc_event_pkg::evt_id_t        push_id_o,

    output fc_event_pkg::evt_lines_t     line_strb_o
);

    fc_event_pkg::evt_lines_t events_prev_q;
    fc_event_pkg::evt_lines_t line_strb_q;

    // ****************************************
    // Event line edge detection
    // ****************************************

    // Previous sample of the lines so a line held high fires once
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            events_prev_q <= '0;
            line_strb_q   <= '0;
        end else begin
            events_prev_q <= events_i;
            line_strb_q   <= events_i & ~events_prev_q;
        end
    end

    assign line_strb_o = line_strb_q;

    // ****************************************
    // Peripheral event acceptance
    // ****************************************

    // Accepted whenever the source is valid and the queue has room
    assign event_fifo_fulln_o = ~fifo_full_i;
    assign push_o             = event_fifo_valid_i & ~fifo_full_i;
    assign push_id_o          = event_fifo_data_i;

endmodule

`default_nettype wire

// ==== fc_event_fifo.sv ====
// Circular queue of peripheral event IDs kept in arrival order
`default_nettype none

`include "fc_event_params.svh"

module fc_event_fifo #(
    parameter int DEPTH = `FC_EVT_FIFO_DEPTH
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,

    input  wire logic                  push_i,
    input  wire fc_event_pkg::evt_id_t push_id_i,
    output logic                       full_o,

    input  wire logic                  pop_i,
    output logic                       not_empty_o,
    output fc_event_pkg::evt_id_t      head_id_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    fc_event_pkg::evt_id_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_id_i;
        end
    end

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign full_o      = (count_q == CNT_FULL);
    assign not_empty_o = (count_q != '0);
    assign head_id_o   = mem_q[rd_ptr_q];

    // Producer and consumer must honour the flags
    push_not_full_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o)
        else $error("push into a full event queue");

    pop_not_empty_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> not_empty_o)
        else $error("pop from an empty event queue");

endmodule

`default_nettype wire

// ==== fc_irq_ctrl.sv ====
// Interrupt controller with pending and mask state, APB registers and queue drain
`default_nettype none

`include "fc_event_params.svh"

module fc_irq_ctrl (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,

    input  wire fc_event_pkg::evt_lines_t line_strb_i,

    input  wire logic                     fifo_not_empty_i,
    input  wire fc_event_pkg::evt_id_t    fifo_head_id_i,
    output logic                          fifo_pop_o,

    fc_apb_if.regs                        apb,

    output logic                          irq_req_o,
    output fc_event_pkg::irq_id_t         irq_id_o,
    input  wire logic                     irq_ack_i,
    input  wire fc_event_pkg::irq_id_t    irq_ack_id_i
);

    fc_event_pkg::evt_lines_t pending_q;
    fc_event_pkg::evt_lines_t mask_q;
    fc_event_pkg::evt_id_t    evtid_q;

    fc_event_pkg::evt_lines_t pending_set;
    fc_event_pkg::evt_lines_t pending_clr;
    fc_event_pkg::evt_lines_t active;

    fc_reg_pkg::reg_sel_e     reg_sel;
    logic                     apb_wr;
    logic                     apb_rd;

    // ****************************************
    // Queue drain onto the queue line
    // ****************************************

    // Next queue event moves in only once the previous one is acknowledged
    assign fifo_pop_o = fifo_not_empty_i & ~pending_q[`FC_IRQ_QUEUE_LINE];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            evtid_q <= '0;
        end else if (fifo_pop_o) begin
            evtid_q <= fifo_head_id_i;
        end
    end

    // ****************************************
    // Pending register
    // ****************************************

    always_comb begin
        pending_set = line_strb_i;
        pending_set[`FC_IRQ_QUEUE_LINE] = line_strb_i[`FC_IRQ_QUEUE_LINE] | fifo_pop_o;
        pending_clr = '0;
        if (irq_ack_i) begin
            pending_clr[irq_ack_id_i] = 1'b1;
        end
    end

    // A new event beats an acknowledge of the same line
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= (pending_q & ~pending_clr) | pending_set;
        end
    end

    // ****************************************
    // APB register access
    // ****************************************

    always_comb begin
        case (apb.paddr)
            fc_reg_pkg::apb_addr_t'(`FC_REG_MASK_OFS):    reg_sel = fc_reg_pkg::REG_MASK;
            fc_reg_pkg::apb_addr_t'(`FC_REG_PENDING_OFS): reg_sel = fc_reg_pkg::REG_PENDING;
            fc_reg_pkg::apb_addr_t'(`FC_REG_EVTID_OFS):   reg_sel = fc_reg_pkg::REG_EVTID;
            default:                                      reg_sel = fc_reg_pkg::REG_NONE;
        endcase
    end

    // Transfers complete in the access cycle
    assign apb_wr = apb.psel & apb.penable & apb.pwrite;
    assign apb_rd = apb.psel & ~apb.pwrite;

    // Only MASK is writable
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mask_q <= '0;
        end else if (apb_wr && (reg_sel == fc_reg_pkg::REG_MASK)) begin
            mask_q <= fc_event_pkg::evt_lines_t'(apb.pwdata);
        end
    end

    always_comb begin
        apb.prdata = '0;
        if (apb_rd) begin
            case (reg_sel)
                fc_reg_pkg::REG_MASK:    apb.prdata = fc_reg_pkg::apb_data_t'(mask_q);
                fc_reg_pkg::REG_PENDING: apb.prdata = fc_reg_pkg::apb_data_t'(pending_q);
                fc_reg_pkg::REG_EVTID:   apb.prdata = fc_reg_pkg::apb_data_t'(evtid_q);
                default:                 apb.prdata = '0;
            endcase
        end
    end

    // ****************************************
    // Core interrupt request
    // ****************************************

    assign active    = pending_q & mask_q;
    assign irq_req_o = |active;

    // Highest masked pending line wins
    always_comb begin
        irq_id_o = '0;
        for (int k = 0; k < `FC_EVT_LINES; k++) begin
            if (active[k]) begin
                irq_id_o = fc_event_pkg::irq_id_t'(k);
            end
        end
    end

    // The core only acknowledges an outstanding request
    ack_with_req_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_ack_i |-> irq_req_o)
        else $error("interrupt acknowledge without a request");

endmodule

`default_nettype wire

// ==== fc_event_unit.sv ====
// Event unit top level joining event intake, event queue and interrupt controller
`default_nettype none

module fc_event_unit (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,

    // Event lines and peripheral event queue
    input  wire fc_event_pkg::evt_lines_t events_i,
    input  wire logic                     event_fifo_valid_i,
    input  wire fc_event_pkg::evt_id_t    event_fifo_data_i,
    output logic                          event_fifo_fulln_o,

    // APB register port
    input  wire logic                     apb_psel_i,
    input  wire logic                     apb_penable_i,
    input  wire logic                     apb_pwrite_i,
    input  wire fc_reg_pkg::apb_addr_t    apb_paddr_i,
    input  wire fc_reg_pkg::apb_data_t    apb_pwdata_i,
    output fc_reg_pkg::apb_data_t         apb_prdata_o,

    // Core interrupt
    output logic                          irq_req_o,
    output fc_event_pkg::irq_id_t         irq_id_o,
    input  wire logic                     irq_ack_i,
    input  wire fc_event_pkg::irq_id_t    irq_ack_id_i
);

    logic                     fifo_full;
    logic                     fifo_push;
    fc_event_pkg::evt_id_t    fifo_push_id;
    logic                     fifo_pop;
    logic                     fifo_not_empty;
    fc_event_pkg::evt_id_t    fifo_head_id;
    fc_event_pkg::evt_lines_t line_strb;

    fc_apb_if apb_if ();

    // Bus side of the register port
    assign apb_if.psel    = apb_psel_i;
    assign apb_if.penable = apb_penable_i;
    assign apb_if.pwrite  = apb_pwrite_i;
    assign apb_if.paddr   = apb_paddr_i;
    assign apb_if.pwdata  = apb_pwdata_i;
    assign apb_prdata_o   = apb_if.prdata;

    fc_event_intake i_intake (
        .clk_i              ( clk_i              ),
        .rst_n_i            ( rst_n_i            ),
        .events_i           ( events_i           ),
        .event_fifo_valid_i ( event_fifo_valid_i ),
        .event_fifo_data_i  ( event_fifo_data_i  ),
        .event_fifo_fulln_o ( event_fifo_fulln_o ),
        .fifo_full_i        ( fifo_full          ),
        .push_o             ( fifo_push          ),
        .push_id_o          ( fifo_push_id       ),
        .line_strb_o        ( line_strb          )
    );

    fc_event_fifo i_fifo (
        .clk_i       ( clk_i          ),
        .rst_n_i     ( rst_n_i        ),
        .push_i      ( fifo_push      ),
        .push_id_i   ( fifo_push_id   ),
        .full_o      ( fifo_full      ),
        .pop_i       ( fifo_pop       ),
        .not_empty_o ( fifo_not_empty ),
        .head_id_o   ( fifo_head_id   )
    );

    fc_irq_ctrl i_irq_ctrl (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .line_strb_i      ( line_strb      ),
        .fifo_not_empty_i ( fifo_not_empty ),
        .fifo_head_id_i   ( fifo_head_id   ),
        .fifo_pop_o       ( fifo_pop       ),
        .apb              ( apb_if.regs    ),
        .irq_req_o        ( irq_req_o      ),
        .irq_id_o         ( irq_id_o       ),
        .irq_ack_i        ( irq_ack_i      ),
        .irq_ack_id_i     ( irq_ack_id_i   )
    );

endmodule

`default_nettype wire

// ==== fc_event_checker.sv ====
// Event unit checker holding a reference model and comparing DUT outputs on every rising edge
`default_nettype none

`include "fc_event_params.svh"

module fc_event_checker (
    input  wire logic                     clk_i,
    input  wire logic                     rst_n_i,
    input  wire fc_event_pkg::evt_lines_t events_i,
    input  wire logic                     event_fifo_valid_i,
    input  wire fc_event_pkg::evt_id_t    event_fifo_data_i,
    input  wire logic                     fulln_i,
    input  wire logic                     apb_psel_i,
    input  wire logic                     apb_penable_i,
    input  wire logic                     apb_pwrite_i,
    input  wire fc_reg_pkg::apb_addr_t    apb_paddr_i,
    input  wire fc_reg_pkg::apb_data_t    apb_pwdata_i,
    input  wire fc_reg_pkg::apb_data_t    prdata_i,
    input  wire logic                     irq_req_i,
    input  wire fc_event_pkg::irq_id_t    irq_id_i,
    input  wire logic                     irq_ack_i,
    input  wire fc_event_pkg::irq_id_t    irq_ack_id_i,
    output int                            error_count_o
);

    // Modelled state
    fc_event_pkg::evt_lines_t pend_m;
    fc_event_pkg::evt_lines_t mask_m;
    fc_event_pkg::evt_lines_t prev_m;
    fc_event_pkg::evt_lines_t strb_m;
    fc_event_pkg::evt_id_t    evtid_m;
    fc_event_pkg::evt_id_t    queue_m[$];

    logic                     exp_req;
    fc_event_pkg::irq_id_t    exp_id;
    fc_reg_pkg::apb_data_t    exp_rdata;
    logic                     exp_fulln;
    logic                     take_head;
    int                       errors = 0;

    assign error_count_o = errors;

    // Expected request, ID, register read and not-full from the modelled state
    function automatic void expected_outputs(
        input  fc_event_pkg::evt_lines_t pend,
        input  fc_event_pkg::evt_lines_t mask,
        input  fc_event_pkg::evt_id_t    evtid,
        input  int                       queued,
        input  fc_reg_pkg::apb_addr_t    addr,
        output logic                     req,
        output fc_event_pkg::irq_id_t    id,
        output fc_reg_pkg::apb_data_t    rdata,
        output logic                     fulln
    );
        fc_event_pkg::evt_lines_t both;
        int                       k;
        both = pend & mask;
        req  = (both != '0);
        k    = `FC_EVT_LINES - 1;
        while (k > 0 && !both[k]) begin
            k--;
        end
        id = fc_event_pkg::irq_id_t'(k);
        case (addr)
            `FC_REG_MASK_OFS:    rdata = mask;
            `FC_REG_PENDING_OFS: rdata = pend;
            `FC_REG_EVTID_OFS:   rdata = fc_reg_pkg::apb_data_t'(evtid);
            default:             rdata = '0;
        endcase
        fulln = (queued < `FC_EVT_FIFO_DEPTH);
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // ****************************************
    // Compare, then advance the model
    // ****************************************
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_m  = '0;
            mask_m  = '0;
            prev_m  = '0;
            strb_m  = '0;
            evtid_m = '0;
            queue_m.delete();
        end else begin
            expected_outputs(pend_m, mask_m, evtid_m, queue_m.size(), apb_paddr_i,
                             exp_req, exp_id, exp_rdata, exp_fulln);
            compare_value("irq_req_o", irq_req_i, exp_req);
            compare_value("irq_id_o", irq_id_i, exp_id);
            compare_value("event_fifo_fulln_o", fulln_i, exp_fulln);
            if (apb_psel_i && apb_penable_i && !apb_pwrite_i) begin
                compare_value("apb_prdata_o", prdata_i, exp_rdata);
            end

            // Head moves in only while the queue line is clear
            take_head = (queue_m.size() != 0) && !pend_m[`FC_IRQ_QUEUE_LINE];
            if (irq_ack_i) begin
                pend_m[irq_ack_id_i] = 1'b0;
            end
            pend_m = pend_m | strb_m;
            if (take_head) begin
                evtid_m = queue_m.pop_front();
                pend_m[`FC_IRQ_QUEUE_LINE] = 1'b1;
            end
            if (event_fifo_valid_i && exp_fulln) begin
                queue_m.push_back(event_fifo_data_i);
            end
            if (apb_psel_i && apb_penable_i && apb_pwrite_i
                    && apb_paddr_i == `FC_REG_MASK_OFS) begin
                mask_m = apb_pwdata_i;
            end
            strb_m = events_i & ~prev_m;
            prev_m = events_i;
        end
    end

endmodule

`default_nettype wire

// ==== tb_fc_event_unit.sv ====
// Testbench for the event unit with directed tests and a seeded random mix
`default_nettype none

`include "fc_event_params.svh"

module tb_fc_event_unit;

    // Cycle budget of each test
    localparam int BUDGET_RESET  = 60;
    localparam int BUDGET_LINES  = 120;
    localparam int BUDGET_MASK   = 80;
    localparam int BUDGET_QUEUE  = 120;
    localparam int BUDGET_BACKP  = 200;
    localparam int BUDGET_RANDOM = 700;
    localparam int CYCLE_LIMIT   = 2 * (BUDGET_RESET + BUDGET_LINES + BUDGET_MASK
                                        + BUDGET_QUEUE + BUDGET_BACKP + BUDGET_RANDOM);

    logic                     clk_i;
    logic                     rst_n_i;
    fc_event_pkg::evt_lines_t events_i;
    logic                     event_fifo_valid_i;
    fc_event_pkg::evt_id_t    event_fifo_data_i;
    logic                     event_fifo_fulln_o;
    logic                     apb_psel_i;
    logic                     apb_penable_i;
    logic                     apb_pwrite_i;
    fc_reg_pkg::apb_addr_t    apb_paddr_i;
    fc_reg_pkg::apb_data_t    apb_pwdata_i;
    fc_reg_pkg::apb_data_t    apb_prdata_o;
    logic                     irq_req_o;
    fc_event_pkg::irq_id_t    irq_id_o;
    logic                     irq_ack_i;
    fc_event_pkg::irq_id_t    irq_ack_id_i;

    int     checker_errors;
    int     tb_errors = 0;
    int     errors_before = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     cycle_count = 0;
    integer seed;
    integer action;

    fc_event_unit fc_event_unit_inst (.*);

    fc_event_checker event_checker_inst (
        .clk_i, .rst_n_i, .events_i, .event_fifo_valid_i, .event_fifo_data_i,
        .fulln_i (event_fifo_fulln_o),
        .apb_psel_i, .apb_penable_i, .apb_pwrite_i, .apb_paddr_i, .apb_pwdata_i,
        .prdata_i (apb_prdata_o),
        .irq_req_i (irq_req_o),
        .irq_id_i (irq_id_o),
        .irq_ack_i, .irq_ack_id_i,
        .error_count_o (checker_errors)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // ****************************************
    // Bus master and core tasks
    // ****************************************
    task automatic apb_access(input logic write, input fc_reg_pkg::apb_addr_t addr,
                              input fc_reg_pkg::apb_data_t data);
        @(negedge clk_i);
        apb_psel_i    = 1'b1;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = write;
        apb_paddr_i   = addr;
        apb_pwdata_i  = data;
        @(negedge clk_i);
        apb_penable_i = 1'b1;
        @(negedge clk_i);
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b0;
    endtask

    // Source holds valid and ID until the queue takes it
    task automatic push_event(input fc_event_pkg::evt_id_t id);
        logic taken;
        @(negedge clk_i);
        event_fifo_valid_i = 1'b1;
        event_fifo_data_i  = id;
        taken = 1'b0;
        while (!taken) begin
            taken = event_fifo_fulln_o;
            @(negedge clk_i);
        end
        event_fifo_valid_i = 1'b0;
    endtask

    task automatic wait_req(input int limit);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!irq_req_o && n < limit) begin
            @(negedge clk_i);
            n++;
        end
        if (!irq_req_o) begin
            $display("interrupt request did not rise within %0d cycles", limit);
            tb_errors++;
        end
    endtask

    // Acknowledge whatever the core is offered while requested
    task automatic ack_top();
        @(negedge clk_i);
        if (irq_req_o) begin
            irq_ack_i    = 1'b1;
            irq_ack_id_i = irq_id_o;
            @(negedge clk_i);
            irq_ack_i    = 1'b0;
        end
    endtask

    task automatic drain_queue(input int n);
        repeat (n) begin
            wait_req(20);
            apb_access(1'b0, `FC_REG_EVTID_OFS, '0);
            ack_top();
        end
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = checker_errors + tb_errors - errors_before;
        if (errs == 0) begin
            $display("test %s: ok", name);
            pass_count++;
        end else begin
            $display("test %s: %0d errors", name, errs);
            fail_count++;
        end
        errors_before = checker_errors + tb_errors;
    endtask

    initial begin
        rst_n_i = 1'b0;
        events_i = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i = '0;
        apb_psel_i = 1'b0;
        apb_penable_i = 1'b0;
        apb_pwrite_i = 1'b0;
        apb_paddr_i = '0;
        apb_pwdata_i = '0;
        irq_ack_i = 1'b0;
        irq_ack_id_i = '0;
        seed = 32'h2a75_6d7c;
        repeat (10) @(negedge clk_i);
        rst_n_i = 1'b1;

        apb_access(1'b0, `FC_REG_MASK_OFS, '0);
        apb_access(1'b0, `FC_REG_PENDING_OFS, '0);
        apb_access(1'b0, `FC_REG_EVTID_OFS, '0);
        report_test("reset");

        // Lines 2 and 11 stay high through both acknowledges
        apb_access(1'b1, `FC_REG_MASK_OFS, 32'h8000_0f0f);
        apb_access(1'b0, `FC_REG_MASK_OFS, '0);
        @(negedge clk_i);
        events_i = 32'h0000_0804;
        wait_req(10);
        apb_access(1'b0, `FC_REG_PENDING_OFS, '0);
        ack_top();
        ack_top();
        apb_access(1'b0, `FC_REG_PENDING_OFS, '0);
        events_i = '0;
        report_test("event lines");

        apb_access(1'b1, `FC_REG_MASK_OFS, '0);
        @(negedge clk_i);
        events_i = 32'h0000_0020;
        repeat (3) @(negedge clk_i);
        events_i = '0;
        apb_access(1'b0, `FC_REG_PENDING_OFS, '0);
        apb_access(1'b1, `FC_REG_MASK_OFS, 32'h0000_0020);
        wait_req(5);
        ack_top();
        report_test("masking");

        apb_access(1'b1, `FC_REG_MASK_OFS, 32'h1 << `FC_IRQ_QUEUE_LINE);
        push_event(8'h11);
        push_event(8'h22);
        push_event(8'h33);
        drain_queue(3);
        report_test("queue order");

        // First entry parks on the queue line and four more fill the FIFO
        for (int i = 1; i <= 5; i++) begin
            push_event(fc_event_pkg::evt_id_t'(8'h60 + i));
        end
        apb_access(1'b0, `FC_REG_PENDING_OFS, '0);
        fork
            push_event(8'h66);
            begin
                repeat (4) @(negedge clk_i);
                ack_top();
            end
        join
        drain_queue(5);
        report_test("back-pressure");

        repeat (150) begin
            action = $random(seed);
            case (action & 7)
                0, 1: begin
                    @(negedge clk_i);
                    events_i = $random(seed) & $random(seed);
                end
                2, 3: begin
                    @(negedge clk_i);
                    event_fifo_valid_i = 1'b1;
                    event_fifo_data_i  = fc_event_pkg::evt_id_t'($random(seed));
                    @(negedge clk_i);
                    event_fifo_valid_i = 1'b0;
                end
                4: apb_access(1'b1, `FC_REG_MASK_OFS, $random(seed));
                5: apb_access(1'b0, fc_reg_pkg::apb_addr_t'((action >> 3) & 12), '0);
                default: ack_top();
            endcase
        end
        events_i = '0;
        report_test("random mix");

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
fc_event_pkg.sv
fc_reg_pkg.sv
fc_apb_if.sv
fc_event_intake.sv
fc_event_fifo.sv
fc_irq_ctrl.sv
fc_event_unit.sv
fc_event_checker.sv
tb_fc_event_unit.sv
